// ==== src/mist_pkg.sv ====
package mist_pkg;

    // Native game video with 4 bits per colour
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        logic       hs;
        logic       vs;
    } game_video_t;

    // Scan-doubled video coming back from the board
    typedef struct packed {
        logic [5:0] r;
        logic [5:0] g;
        logic [5:0] b;
        logic       hs;
        logic       vs;
    } board_video_t;

    typedef struct packed {
        logic [5:0] r;
        logic [5:0] g;
        logic [5:0] b;
        logic       hs;
        logic       vs;
    } vga_t;

    typedef struct packed {
        logic [5:0] r;
        logic [5:0] g;
        logic [5:0] b;
        logic       hsync;
        logic       vsync;
        logic       csync;
        logic       ypbpr;
        logic       bypass;  // Composite sync on HS and VS tied high
    } mix_t;

    typedef struct packed {
        logic [31:0] status;
        logic [31:0] joystick1;
        logic [31:0] joystick2;
        logic        ypbpr;
        logic        scandoubler_disable;
    } cfg_t;

    typedef struct packed {
        logic [7:0] data;
        logic       first;  // First byte after select fall
    } spi_byte_t;

    // User I/O commands
    localparam logic [7:0] CMD_JOY1   = 8'h01;
    localparam logic [7:0] CMD_JOY2   = 8'h02;
    localparam logic [7:0] CMD_STATUS = 8'h1E;
    localparam logic [7:0] CMD_VMODE  = 8'h23;

    // Download commands
    localparam logic [7:0] DL_START = 8'h54;
    localparam logic [7:0] DL_END   = 8'h55;
    localparam logic [7:0] DL_DATA  = 8'h56;

    // Boards start out with the scan doubler off
    localparam cfg_t CFG_RESET = '{
        status:              32'd0,
        joystick1:           32'd0,
        joystick2:           32'd0,
        ypbpr:               1'b0,
        scandoubler_disable: 1'b1
    };

endpackage

// ==== src/spi_byte_rx.sv ====
`timescale 1ns/1ps

module spi_byte_rx import mist_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      spi_sck_i,
    input  logic      spi_di_i,
    input  logic      spi_ss_i,      // Active low select
    output spi_byte_t byte_o,
    output logic      byte_valid_o
);

    logic [1:0] sck_sync, di_sync, ss_sync;
    logic       sck_q;
    logic       ss_q;
    logic [7:0] shift_q;
    logic [2:0] bit_cnt;
    logic       first_q;
    logic       sck_rise;
    logic       ss_fall;

    assign sck_rise = sck_sync[1] & ~sck_q;
    assign ss_fall  = ss_q & ~ss_sync[1];

    // Two-stage synchronizers on all SPI pins
    always_ff @(posedge clk) begin
        if (reset_i) begin
            sck_sync <= 2'b00;
            di_sync  <= 2'b00;
            ss_sync  <= 2'b11;
            sck_q    <= 1'b0;
            ss_q     <= 1'b1;
        end else begin
            sck_sync <= {sck_sync[0], spi_sck_i};
            di_sync  <= {di_sync[0], spi_di_i};
            ss_sync  <= {ss_sync[0], spi_ss_i};
            sck_q    <= sck_sync[1];
            ss_q     <= ss_sync[1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            bit_cnt      <= 3'd0;
            first_q      <= 1'b0;
            byte_valid_o <= 1'b0;
        end else begin
            byte_valid_o <= 1'b0;
            if (ss_fall) first_q <= 1'b1;
            if (ss_sync[1]) begin
                bit_cnt <= 3'd0;      // Idle while deselected
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    byte_valid_o <= 1'b1;
                    first_q      <= 1'b0;
                end
            end
        end
    end

    // MSB first shift with the byte captured on the eighth bit
    always_ff @(posedge clk) begin
        if (!ss_sync[1] && sck_rise) begin
            shift_q <= {shift_q[6:0], di_sync[1]};
            if (bit_cnt == 3'd7) begin
                byte_o.data  <= {shift_q[6:0], di_sync[1]};
                byte_o.first <= first_q;
            end
        end
    end

endmodule

// ==== src/user_io_decode.sv ====
`timescale 1ns/1ps

module user_io_decode import mist_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  spi_byte_t byte_i,
    input  logic      byte_valid_i,
    output cfg_t      cfg_o
);

    logic [7:0]  cmd_q;
    logic [2:0]  idx_q;        // Data bytes taken so far
    logic [31:0] stage_q;
    logic [31:0] stage_nxt;
    logic [2:0]  cmd_len;
    logic        data_byte;
    logic        last_byte;

    // Payload length per command
    always_comb begin
        case (cmd_q)
            CMD_JOY1,
            CMD_JOY2,
            CMD_STATUS: cmd_len = 3'd4;
            CMD_VMODE:  cmd_len = 3'd1;
            default:    cmd_len = 3'd0;  // Unknown command takes nothing
        endcase
    end

    // Little endian fill of the staging word
    always_comb begin
        stage_nxt = stage_q;
        stage_nxt[{idx_q[1:0], 3'b000} +: 8] = byte_i.data;
    end

    assign data_byte = !byte_i.first && (idx_q < cmd_len);
    assign last_byte = data_byte && (idx_q == cmd_len - 3'd1);

    always_ff @(posedge clk) begin
        if (byte_valid_i && data_byte) begin
            stage_q <= stage_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cmd_q <= 8'd0;
            idx_q <= 3'd0;
            cfg_o <= CFG_RESET;
        end else if (byte_valid_i) begin
            if (byte_i.first) begin
                cmd_q <= byte_i.data;
                idx_q <= 3'd0;
            end else if (data_byte) begin
                idx_q <= idx_q + 3'd1;
            end

            // Fields change only once complete
            if (last_byte) begin
                case (cmd_q)
                    CMD_JOY1:   cfg_o.joystick1 <= stage_nxt;
                    CMD_JOY2:   cfg_o.joystick2 <= stage_nxt;
                    CMD_STATUS: cfg_o.status    <= stage_nxt;
                    CMD_VMODE: begin
                        cfg_o.ypbpr               <= byte_i.data[0];
                        cfg_o.scandoubler_disable <= byte_i.data[1];
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== src/data_io_decode.sv ====
`timescale 1ns/1ps

module data_io_decode import mist_pkg::*; #(
    parameter int AW = 22
) (
    input  logic          clk,
    input  logic          reset_i,
    input  spi_byte_t     byte_i,
    input  logic          byte_valid_i,
    output logic          downloading_o,
    output logic          ioctl_wr_o,
    output logic [AW-1:0] ioctl_addr_o,
    output logic [7:0]    ioctl_data_o
);

    logic [7:0] cmd_q;
    logic       rom_byte;

    // Data byte inside a DL_DATA select while downloading
    assign rom_byte = byte_valid_i && !byte_i.first &&
                      (cmd_q == DL_DATA) && downloading_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cmd_q <= 8'd0;
        end else if (byte_valid_i && byte_i.first) begin
            cmd_q <= byte_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            downloading_o <= 1'b0;
        end else if (byte_valid_i && byte_i.first) begin
            if (byte_i.data == DL_START) begin
                downloading_o <= 1'b1;
            end else if (byte_i.data == DL_END) begin
                downloading_o <= 1'b0;
            end
        end
    end

    // One cycle write pulse per ROM byte
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ioctl_wr_o <= 1'b0;
        end else begin
            ioctl_wr_o <= rom_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (rom_byte) ioctl_data_o <= byte_i.data;
    end

    // Address moves on once the write has been seen
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ioctl_addr_o <= '0;
        end else begin
            if (ioctl_wr_o) begin
                ioctl_addr_o <= ioctl_addr_o + 1'b1;
            end
            if (byte_valid_i && byte_i.first && byte_i.data == DL_START) begin
                ioctl_addr_o <= '0;
            end
        end
    end

endmodule

// ==== src/video_mix.sv ====
`timescale 1ns/1ps

module video_mix import mist_pkg::*; (
    input  logic         clk,
    input  logic         reset_i,
    input  game_video_t  game_i,
    input  board_video_t board_i,
    input  cfg_t         cfg_i,
    output mix_t         mix_o
);

    logic [5:0] r_sel;
    logic [5:0] g_sel;
    logic [5:0] b_sel;
    logic       hsync;
    logic       vsync;
    logic       csync;
    logic       bypass;

    // Game video goes straight out when the scan doubler is off
    always_comb begin
        if (cfg_i.scandoubler_disable) begin
            r_sel = {game_i.r, game_i.r[3:2]};  // Stretch 4 to 6 bits
            g_sel = {game_i.g, game_i.g[3:2]};
            b_sel = {game_i.b, game_i.b[3:2]};
            hsync = ~game_i.hs;
            vsync = ~game_i.vs;
        end else begin
            r_sel = board_i.r;
            g_sel = board_i.g;
            b_sel = board_i.b;
            hsync = board_i.hs;
            vsync = board_i.vs;
        end
    end

    assign csync  = ~(hsync ^ vsync);
    // 15 kHz modes and YPbPr want composite sync
    assign bypass = cfg_i.scandoubler_disable | cfg_i.ypbpr;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mix_o <= '0;
        end else begin
            mix_o.r      <= r_sel;
            mix_o.g      <= g_sel;
            mix_o.b      <= b_sel;
            mix_o.hsync  <= hsync;
            mix_o.vsync  <= vsync;
            mix_o.csync  <= csync;
            mix_o.ypbpr  <= cfg_i.ypbpr;
            mix_o.bypass <= bypass;
        end
    end

endmodule

// ==== src/video_out.sv ====
`timescale 1ns/1ps

module video_out import mist_pkg::*; (
    input  logic clk,
    input  logic reset_i,
    input  mix_t mix_i,
    output vga_t vga_o
);

    logic signed [13:0] r_s, g_s, b_s;
    logic        [12:0] y_sum;
    logic signed [13:0] pb_sum, pr_sum;
    logic signed [13:0] y_val, pb_val, pr_val;

    function automatic logic [5:0] clamp6(input logic signed [13:0] v);
        if (v < 14'sd0) begin
            return 6'd0;
        end else if (v > 14'sd63) begin
            return 6'd63;
        end
        return v[5:0];
    endfunction

    assign r_s = signed'({8'd0, mix_i.r});
    assign g_s = signed'({8'd0, mix_i.g});
    assign b_s = signed'({8'd0, mix_i.b});

    // Luma weights sum to 64
    assign y_sum = 13'd19 * {7'd0, mix_i.r} + 13'd38 * {7'd0, mix_i.g}
                 + 13'd7 * {7'd0, mix_i.b};
    assign y_val = signed'({1'b0, y_sum >> 6});

    // Arithmetic shift floors the colour difference toward minus infinity
    assign pb_sum = (b_s <<< 5) - 14'sd11 * r_s - 14'sd21 * g_s;
    assign pr_sum = (r_s <<< 5) - 14'sd27 * g_s - 14'sd5 * b_s;
    assign pb_val = (pb_sum >>> 7) + 14'sd32;
    assign pr_val = (pr_sum >>> 7) + 14'sd32;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vga_o <= '0;
        end else begin
            if (mix_i.ypbpr) begin
                vga_o.r <= clamp6(pr_val);  // Pr on red pin
                vga_o.g <= clamp6(y_val);
                vga_o.b <= clamp6(pb_val);
            end else begin
                vga_o.r <= mix_i.r;
                vga_o.g <= mix_i.g;
                vga_o.b <= mix_i.b;
            end
            // SCART cables switch to RGB with VS high
            vga_o.hs <= mix_i.bypass ? mix_i.csync : mix_i.hsync;
            vga_o.vs <= mix_i.bypass ? 1'b1 : mix_i.vsync;
        end
    end

endmodule

// ==== src/mist_base.sv ====
`timescale 1ns/1ps

module mist_base import mist_pkg::*; #(
    parameter int AW = 22        // ROM download address width
) (
    input  logic          clk,
    input  logic          reset_i,
    // SPI from the I/O controller
    input  logic          spi_sck_i,
    input  logic          spi_di_i,
    input  logic          conf_data0_i,
    input  logic          spi_ss2_i,
    // Video
    input  game_video_t   game_i,
    input  board_video_t  board_i,
    output vga_t          vga_o,
    // Control
    output logic [31:0]   status_o,
    output logic [31:0]   joystick1_o,
    output logic [31:0]   joystick2_o,
    // ROM download
    output logic          downloading_o,
    output logic [AW-1:0] ioctl_addr_o,
    output logic [7:0]    ioctl_data_o,
    output logic          ioctl_wr_o
);

    spi_byte_t user_byte, data_byte;
    logic      user_valid, data_valid;
    cfg_t      cfg;
    mix_t      mix;

    assign status_o    = cfg.status;
    assign joystick1_o = cfg.joystick1;
    assign joystick2_o = cfg.joystick2;

    spi_byte_rx u_user_rx (
        .clk          ( clk          ),
        .reset_i      ( reset_i      ),
        .spi_sck_i    ( spi_sck_i    ),
        .spi_di_i     ( spi_di_i     ),
        .spi_ss_i     ( conf_data0_i ),
        .byte_o       ( user_byte    ),
        .byte_valid_o ( user_valid   )
    );

    spi_byte_rx u_data_rx (
        .clk          ( clk          ),
        .reset_i      ( reset_i      ),
        .spi_sck_i    ( spi_sck_i    ),
        .spi_di_i     ( spi_di_i     ),
        .spi_ss_i     ( spi_ss2_i    ),
        .byte_o       ( data_byte    ),
        .byte_valid_o ( data_valid   )
    );

    user_io_decode u_user_io (
        .clk          ( clk        ),
        .reset_i      ( reset_i    ),
        .byte_i       ( user_byte  ),
        .byte_valid_i ( user_valid ),
        .cfg_o        ( cfg        )
    );

    data_io_decode #(.AW(AW)) u_data_io (
        .clk           ( clk           ),
        .reset_i       ( reset_i       ),
        .byte_i        ( data_byte     ),
        .byte_valid_i  ( data_valid    ),
        .downloading_o ( downloading_o ),
        .ioctl_wr_o    ( ioctl_wr_o    ),
        .ioctl_addr_o  ( ioctl_addr_o  ),
        .ioctl_data_o  ( ioctl_data_o  )
    );

    video_mix u_video_mix (
        .clk     ( clk     ),
        .reset_i ( reset_i ),
        .game_i  ( game_i  ),
        .board_i ( board_i ),
        .cfg_i   ( cfg     ),
        .mix_o   ( mix     )
    );

    video_out u_video_out (
        .clk     ( clk     ),
        .reset_i ( reset_i ),
        .mix_i   ( mix     ),
        .vga_o   ( vga_o   )
    );

endmodule

// ==== verif/mist_base_tb.sv ====
`timescale 1ns/1ps

module mist_base_tb import mist_pkg::*; ();

    localparam int NUM_MSG      = 12;     // Random user messages in test 2
    localparam int PIXELS       = 200;
    localparam int BYTE_CYCLES  = 64;     // 8 bits at 8 clocks each
    localparam int MSG_CYCLES   = 24;     // Select setup and gap
    localparam int MAX_BYTES    = NUM_MSG * 7 + 63 + 2 + 4 * 2 + 2;
    localparam int NUM_MSGS_ALL = NUM_MSG + 5 + 4 + 1;
    localparam int VIDEO_CYCLES = 5 * (PIXELS + 2) + 16;
    localparam int WATCHDOG_CYCLES =
        2 * (MAX_BYTES * BYTE_CYCLES + NUM_MSGS_ALL * MSG_CYCLES + VIDEO_CYCLES);

    logic         clk;
    logic         reset_i;
    logic         spi_sck_i, spi_di_i, conf_data0_i, spi_ss2_i;
    game_video_t  game_i;
    board_video_t board_i;
    vga_t         vga_o;
    logic [31:0]  status_o, joystick1_o, joystick2_o;
    logic         downloading_o, ioctl_wr_o;
    logic [21:0]  ioctl_addr_o;
    logic [7:0]   ioctl_data_o;

    // Reference model state
    logic [31:0] exp_status, exp_joy1, exp_joy2;
    logic        exp_ypbpr, exp_sd;
    logic [7:0]  tx_q[$];                 // Bytes of the next SPI message
    logic [7:0]  rom_q[$];
    int          wr_count = 0;
    int          errors = 0, checks = 0, err_mark = 0;
    int          tests_run = 0, tests_failed = 0;

    mist_base #(.AW(22)) DUT (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors != err_mark) tests_failed++;
        $display("test %0d %s: %s", tests_run, name, (errors == err_mark) ? "ok" : "FAILED");
        err_mark = errors;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic shift_byte(input logic [7:0] b);
        for (int i = 7; i >= 0; i--) begin
            spi_sck_i <= 1'b0;
            spi_di_i  <= b[i];            // MSB first
            wait_cycles(4);
            spi_sck_i <= 1'b1;
            wait_cycles(4);
        end
    endtask

    // Sends tx_q under the user select or the download select
    task automatic spi_message(input logic to_data);
        if (to_data) spi_ss2_i <= 1'b0;
        else conf_data0_i <= 1'b0;
        wait_cycles(4);
        foreach (tx_q[k]) shift_byte(tx_q[k]);
        conf_data0_i <= 1'b1;
        spi_ss2_i    <= 1'b1;
        spi_sck_i    <= 1'b0;
        wait_cycles(8);
    endtask

    task automatic set_vmode(input logic [7:0] mode);
        tx_q.delete();
        tx_q.push_back(CMD_VMODE);
        tx_q.push_back(mode);
        exp_ypbpr = mode[0];
        exp_sd    = mode[1];
        spi_message(1'b0);
    endtask

    function automatic logic [5:0] limit6(input int v);
        if (v < 0) return 6'd0;
        if (v > 63) return 6'd63;
        return v[5:0];
    endfunction

    function automatic vga_t expected_vga(input game_video_t g, input board_video_t bd,
                                          input logic ypb, input logic sd);
        vga_t v;
        int   r, gr, b, y, pb, pr;
        logic hsync, vsync, csync, bypass;
        if (sd) begin
            r     = {g.r, g.r[3:2]};
            gr    = {g.g, g.g[3:2]};
            b     = {g.b, g.b[3:2]};
            hsync = ~g.hs;
            vsync = ~g.vs;
        end else begin
            r     = bd.r;
            gr    = bd.g;
            b     = bd.b;
            hsync = bd.hs;
            vsync = bd.vs;
        end
        csync  = ~(hsync ^ vsync);
        bypass = sd | ypb;
        if (ypb) begin
            y  = (19 * r + 38 * gr + 7 * b) >>> 6;
            pb = 32 + ((32 * b - 11 * r - 21 * gr) >>> 7);
            pr = 32 + ((32 * r - 27 * gr - 5 * b) >>> 7);
            v.r = limit6(pr);
            v.g = limit6(y);
            v.b = limit6(pb);
        end else begin
            v.r = r[5:0];
            v.g = gr[5:0];
            v.b = b[5:0];
        end
        v.hs = bypass ? csync : hsync;
        v.vs = bypass ? 1'b1 : vsync;
        return v;
    endfunction

    // Random pixels every cycle with the result expected two cycles later
    task automatic run_pixels(input int count, input logic corners);
        game_video_t  g;
        board_video_t bd;
        vga_t         exp_q[$];
        logic [31:0]  rnd;
        for (int i = 0; i < count + 2; i++) begin
            if (i < count) begin
                rnd = $urandom;
                g   = rnd[13:0];
                rnd = $urandom;
                bd  = rnd[19:0];
                if (corners && i < 8) begin
                    bd.r = i[0] ? 6'd63 : 6'd0;
                    bd.g = i[1] ? 6'd63 : 6'd0;
                    bd.b = i[2] ? 6'd63 : 6'd0;
                end
                game_i  <= g;
                board_i <= bd;
                exp_q.push_back(expected_vga(g, bd, exp_ypbpr, exp_sd));
            end
            @(negedge clk);
            if (i >= 2) check_value("vga_o", vga_o, exp_q.pop_front());
            @(posedge clk);
        end
    endtask

    // Write pulses checked against the expected ROM bytes
    always @(negedge clk) begin
        if (!reset_i && ioctl_wr_o) begin
            if (wr_count >= rom_q.size()) begin
                $display("unexpected ROM write pulse at address 0x%0h", ioctl_addr_o);
                errors++;
            end else begin
                check_value("ioctl_data_o", ioctl_data_o, rom_q[wr_count]);
                check_value("ioctl_addr_o", ioctl_addr_o, wr_count);
            end
            wr_count++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int unsigned seed_init;
        logic [7:0]  cmd, b;
        logic [31:0] word;
        int          n, kind, sel;
        seed_init    = $urandom(32'h6fc3_4435);
        reset_i      = 1'b1;
        spi_sck_i    = 1'b0;
        spi_di_i     = 1'b0;
        conf_data0_i = 1'b1;
        spi_ss2_i    = 1'b1;
        game_i       = '0;
        board_i      = '0;
        exp_status   = 32'd0;
        exp_joy1     = 32'd0;
        exp_joy2     = 32'd0;
        exp_ypbpr    = 1'b0;
        exp_sd       = 1'b1;
        wait_cycles(2);
        reset_i <= 1'b0;
        wait_cycles(3);

        @(negedge clk);
        check_value("status_o", status_o, 32'd0);
        check_value("joystick1_o", joystick1_o, 32'd0);
        check_value("joystick2_o", joystick2_o, 32'd0);
        check_value("downloading_o", downloading_o, 1'b0);
        check_value("ioctl_wr_o", ioctl_wr_o, 1'b0);
        check_value("ioctl_addr_o", ioctl_addr_o, 22'd0);
        check_value("vga_o", vga_o, expected_vga(game_i, board_i, 1'b0, 1'b1));
        @(posedge clk);
        report_test("reset state");

        for (int m = 0; m < NUM_MSG; m++) begin
            sel  = $urandom_range(3, 0);
            cmd  = (sel == 0) ? CMD_JOY1 : (sel == 1) ? CMD_JOY2 :
                   (sel == 2) ? CMD_STATUS : (8'h80 | 8'($urandom_range(127, 0)));
            kind = $urandom_range(3, 0);
            n    = (kind == 0) ? $urandom_range(3, 0) : (kind == 1) ? $urandom_range(6, 5) : 4;
            word = 32'd0;
            tx_q.delete();
            tx_q.push_back(cmd);
            for (int k = 0; k < n; k++) begin
                b = 8'($urandom);
                tx_q.push_back(b);
                if (k < 4) word[8 * k +: 8] = b;
            end
            if (n >= 4 && sel == 0) exp_joy1 = word;  // Only complete words commit
            if (n >= 4 && sel == 1) exp_joy2 = word;
            if (n >= 4 && sel == 2) exp_status = word;
            spi_message(1'b0);
            @(negedge clk);
            check_value("status_o", status_o, exp_status);
            check_value("joystick1_o", joystick1_o, exp_joy1);
            check_value("joystick2_o", joystick2_o, exp_joy2);
            @(posedge clk);
        end
        report_test("config messages");

        n = $urandom_range(60, 20);
        for (int k = 0; k < n; k++) rom_q.push_back(8'($urandom));
        tx_q.delete();
        tx_q.push_back(DL_START);
        spi_message(1'b1);
        @(negedge clk);
        check_value("downloading_o", downloading_o, 1'b1);
        @(posedge clk);
        tx_q = rom_q;
        tx_q.push_front(DL_DATA);
        spi_message(1'b1);
        tx_q.delete();
        tx_q.push_back(DL_END);
        spi_message(1'b1);
        @(negedge clk);
        check_value("downloading_o", downloading_o, 1'b0);
        check_value("ioctl_wr_o pulse count", wr_count, n);
        check_value("ioctl_addr_o", ioctl_addr_o, n);  // One step per write
        @(posedge clk);
        tx_q.delete();
        tx_q.push_back(DL_START);             // A new download starts again at 0
        spi_message(1'b1);
        @(negedge clk);
        check_value("downloading_o", downloading_o, 1'b1);
        check_value("ioctl_addr_o", ioctl_addr_o, 22'd0);
        @(posedge clk);
        tx_q.delete();
        tx_q.push_back(DL_END);
        spi_message(1'b1);
        @(negedge clk);
        check_value("downloading_o", downloading_o, 1'b0);
        @(posedge clk);
        report_test("rom download");

        for (int v = 0; v < 4; v++) begin
            set_vmode(8'(v));
            run_pixels(PIXELS, 1'b0);
        end
        report_test("video modes");

        set_vmode(8'h01);                     // Board video through YPbPr
        run_pixels(PIXELS, 1'b1);
        report_test("ypbpr output");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== build.f ====
src/mist_pkg.sv
src/spi_byte_rx.sv
src/user_io_decode.sv
src/data_io_decode.sv
src/video_mix.sv
src/video_out.sv
src/mist_base.sv
verif/mist_base_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator and run; pass only when the log holds the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module mist_base_tb \
    -f build.f --Mdir obj_dir -o mist_base_sim > build.log 2>&1 \
    || { cat build.log; echo "build FAILED"; exit 1; }

./obj_dir/mist_base_sim > sim.log 2>&1
cat sim.log

grep -q "^All tests passed!$" sim.log && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }
